// File: dcache_pkg.sv
// Shared geometry, access types and port structs of the L1 data cache data stage
`default_nettype none

package dcache_pkg;
	// Cache geometry
	localparam int L1D_WAYS = 4;
	localparam int L1D_SETS = 64;
	localparam int CACHE_LINE_BYTES = 64;
	localparam int CACHE_LINE_WORDS = 16;
	localparam int CACHE_LINE_OFFSET_WIDTH = 6;
	localparam int SET_IDX_WIDTH = 6;
	localparam int TAG_WIDTH = 20;
	localparam int THREADS_PER_CORE = 4;

	// Upper half of every IO address
	localparam logic [15:0] IO_PAGE_PREFIX = 16'hFFFF;

	typedef logic [31:0] scalar_t;
	typedef scalar_t [CACHE_LINE_WORDS - 1:0] vector_t;
	typedef logic [CACHE_LINE_BYTES * 8 - 1:0] cache_line_data_t;
	typedef logic [$clog2(L1D_WAYS) - 1:0] way_idx_t;
	typedef logic [SET_IDX_WIDTH - 1:0] set_idx_t;
	typedef logic [TAG_WIDTH - 1:0] tag_t;
	typedef logic [$clog2(THREADS_PER_CORE) - 1:0] thread_idx_t;
	typedef logic [CACHE_LINE_WORDS - 1:0] lane_mask_t;
	typedef logic [3:0] subcycle_t;

	typedef enum logic [2:0] {
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_SYNC,
		MEM_BLOCK,
		MEM_SCGATH
	} mem_access_t;

	typedef struct packed {
		tag_t tag;
		set_idx_t set_idx;
		logic [CACHE_LINE_OFFSET_WIDTH - 1:0] offset;
	} cache_addr_t;

	typedef struct packed {
		logic [15:0] prefix;
		logic [15:0] offset;
	} io_addr_t;

	// Same request word seen as a cache address or as an IO address
	typedef union packed {
		cache_addr_t cache;
		io_addr_t io;
	} request_addr_t;

	typedef struct packed {
		logic valid;
		logic is_load;
		mem_access_t access_type;
		scalar_t pc;
		thread_idx_t thread;
		request_addr_t address;
		lane_mask_t lane_mask;
		subcycle_t subcycle;
		vector_t store_value;
	} mem_request_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} way_tag_t;

	typedef struct packed {
		logic en;
		way_idx_t way;
		set_idx_t set;
		cache_line_data_t line;
	} fill_data_t;

	typedef struct packed {
		logic [L1D_WAYS - 1:0] way_en;
		set_idx_t set;
		tag_t tag;
	} fill_tag_t;

	typedef struct packed {
		logic write_en;
		logic read_en;
		thread_idx_t thread;
		scalar_t address;
		scalar_t write_value;
	} io_request_t;

	typedef struct packed {
		logic en;
		logic [CACHE_LINE_BYTES - 1:0] mask;
		scalar_t address;
		cache_line_data_t data;
		thread_idx_t thread;
		logic synchronized;
	} store_request_t;

	typedef struct packed {
		logic en;
		scalar_t address;
		thread_idx_t thread;
		logic synchronized;
	} miss_request_t;

	typedef struct packed {
		logic en;
		way_idx_t way;
	} lru_update_t;

	typedef struct packed {
		logic valid;
		thread_idx_t thread;
		request_addr_t address;
		mem_access_t access_type;
		lane_mask_t lane_mask;
		subcycle_t subcycle;
		logic rollback_en;
		scalar_t rollback_pc;
		logic suspend_thread;
		logic is_io_address;
		logic access_fault;
	} writeback_t;

	typedef struct packed {
		logic cache_load;
		logic cache_store;
		logic io_access;
		logic unaligned;
		logic synchronized;
	} request_class_t;
endpackage

`default_nettype wire

// File: dcache_request_decode.sv
// Request classifier for cache loads, cache stores and IO, with rollback and alignment checks
`timescale 1ns/1ps
`default_nettype none

module dcache_request_decode(
	input dcache_pkg::mem_request_t request,
	input wire logic rollback_en,
	input dcache_pkg::thread_idx_t rollback_thread,
	input wire logic store_mask_nonzero,
	output dcache_pkg::request_class_t req_class);

	import dcache_pkg::*;

	logic is_io_address;
	logic cancelled;
	logic active;
	logic cache_access;

	assign is_io_address = request.address.io.prefix == IO_PAGE_PREFIX;

	// A rollback from writeback squashes the same thread's request here
	assign cancelled = rollback_en && rollback_thread == request.thread;
	assign active = request.valid && !cancelled;

	// Stores with no enabled byte never reach the cache
	assign cache_access = active && !is_io_address
		&& (request.is_load || store_mask_nonzero);

	assign req_class.cache_load = cache_access && request.is_load;
	assign req_class.cache_store = cache_access && !request.is_load;
	assign req_class.io_access = active && is_io_address;
	assign req_class.synchronized = request.access_type == MEM_SYNC;

	always_comb
	begin
		case (request.access_type)
			MEM_S, MEM_SX:
				req_class.unaligned = request.address.cache.offset[0];

			MEM_L, MEM_SYNC, MEM_SCGATH:
				req_class.unaligned = |request.address.cache.offset[1:0];

			// Whole line transfers
			MEM_BLOCK:
				req_class.unaligned = |request.address.cache.offset;

			default:
				req_class.unaligned = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

// File: dcache_hit_check.sv
// Tag compare, hit way encoding and per-thread synchronized load tracking
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_check(
	input wire logic clk,
	input wire logic reset,
	input dcache_pkg::mem_request_t request,
	input dcache_pkg::way_tag_t [dcache_pkg::L1D_WAYS - 1:0] way_tags,
	input dcache_pkg::request_class_t req_class,
	input dcache_pkg::fill_tag_t fill_tag,
	output logic hit,
	output dcache_pkg::way_idx_t hit_way,
	output logic near_miss);

	import dcache_pkg::*;

	logic [L1D_WAYS - 1:0] way_hit_oh;
	logic [THREADS_PER_CORE - 1:0] sync_pending;
	logic cache_access;
	logic fill_matches;

	assign cache_access = req_class.cache_load || req_class.cache_store;

	always_comb
	begin
		for (int way = 0; way < L1D_WAYS; way++)
		begin
			way_hit_oh[way] = way_tags[way].valid
				&& way_tags[way].tag == request.address.cache.tag;
		end
	end

	// A line sits in at most one way, so OR-ing the indices is enough
	always_comb
	begin
		hit_way = '0;
		for (int way = 0; way < L1D_WAYS; way++)
		begin
			if (way_hit_oh[way])
				hit_way = hit_way | way_idx_t'(way);
		end
	end

	// First synchronized load must go to L2 to register, even if the line is here
	assign hit = cache_access && |way_hit_oh
		&& (!req_class.synchronized || sync_pending[request.thread]);

	// Line arrives in this very cycle, so suspending would never be woken
	assign fill_matches = |fill_tag.way_en
		&& fill_tag.set == request.address.cache.set_idx
		&& fill_tag.tag == request.address.cache.tag;
	assign near_miss = req_class.cache_load && !hit && fill_matches
		&& !req_class.synchronized;

	// Toggles between first issue and retry of a synchronized load
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			sync_pending <= '0;
		else if (req_class.cache_load && req_class.synchronized)
			sync_pending[request.thread] <= !sync_pending[request.thread];
	end
endmodule

`default_nettype wire

// File: dcache_store_align.sv
// Store alignment logic building the byte enable mask and big-endian line data
`timescale 1ns/1ps
`default_nettype none

module dcache_store_align(
	input dcache_pkg::mem_request_t request,
	output logic [dcache_pkg::CACHE_LINE_BYTES - 1:0] store_mask,
	output dcache_pkg::cache_line_data_t store_data);

	import dcache_pkg::*;

	lane_mask_t word_mask;
	lane_mask_t lane_oh;
	lane_mask_t subcycle_oh;
	logic [3:0] byte_mask;
	logic [$clog2(CACHE_LINE_WORDS) - 1:0] lane_idx;
	scalar_t scalar_value;
	scalar_t scatter_value;
	cache_line_data_t vector_swapped;

	function automatic scalar_t swap_bytes(input scalar_t value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

	assign lane_idx = request.address.cache.offset[CACHE_LINE_OFFSET_WIDTH - 1:2];

	// Lane 0 sits in the top bit of a lane mask
	assign lane_oh = {1'b1, {(CACHE_LINE_WORDS - 1){1'b0}}} >> lane_idx;
	assign subcycle_oh = {1'b1, {(CACHE_LINE_WORDS - 1){1'b0}}} >> request.subcycle;

	assign scalar_value = request.store_value[0];
	assign scatter_value = request.store_value[~request.subcycle];

	always_comb
	begin
		for (int word = 0; word < CACHE_LINE_WORDS; word++)
			vector_swapped[word * 32+:32] = swap_bytes(request.store_value[word]);
	end

	// Word lanes
	always_comb
	begin
		case (request.access_type)
			MEM_BLOCK:
				word_mask = request.lane_mask;

			// Only the lane of this subcycle, if it is enabled
			MEM_SCGATH:
				word_mask = |(request.lane_mask & subcycle_oh) ? lane_oh : '0;

			default:
				word_mask = lane_oh;
		endcase
	end

	// Bytes within a word, and the data that goes with them
	always_comb
	begin
		case (request.access_type)
			MEM_B, MEM_BX:
			begin
				byte_mask = 4'b1000 >> request.address.cache.offset[1:0];
				store_data = {(CACHE_LINE_BYTES){scalar_value[7:0]}};
			end

			MEM_S, MEM_SX:
			begin
				byte_mask = request.address.cache.offset[1] ? 4'b0011 : 4'b1100;
				store_data = {(CACHE_LINE_BYTES / 2){scalar_value[7:0], scalar_value[15:8]}};
			end

			MEM_L, MEM_SYNC:
			begin
				byte_mask = 4'b1111;
				store_data = {(CACHE_LINE_WORDS){swap_bytes(scalar_value)}};
			end

			MEM_SCGATH:
			begin
				byte_mask = 4'b1111;
				store_data = {(CACHE_LINE_WORDS){swap_bytes(scatter_value)}};
			end

			// Block vector
			default:
			begin
				byte_mask = 4'b1111;
				store_data = vector_swapped;
			end
		endcase
	end

	// Byte b of the line lands on mask bit 63 - b
	always_comb
	begin
		for (int i = 0; i < CACHE_LINE_BYTES; i++)
			store_mask[i] = word_mask[i / 4] & byte_mask[i % 4];
	end
endmodule

`default_nettype wire

// File: dcache_data_sram.sv
// Line storage for all ways and sets, registered read port and L2 fill write port
`timescale 1ns/1ps
`default_nettype none

module dcache_data_sram(
	input wire logic clk,
	input wire logic read_en,
	input dcache_pkg::way_idx_t read_way,
	input dcache_pkg::set_idx_t read_set,
	output dcache_pkg::cache_line_data_t read_data,
	input dcache_pkg::fill_data_t fill_data);

	import dcache_pkg::*;

	cache_line_data_t lines[L1D_WAYS * L1D_SETS];
	logic [$bits(way_idx_t) + $bits(set_idx_t) - 1:0] read_addr;
	logic [$bits(way_idx_t) + $bits(set_idx_t) - 1:0] write_addr;

	assign read_addr = {read_way, read_set};
	assign write_addr = {fill_data.way, fill_data.set};

	always_ff @(posedge clk)
	begin
		if (fill_data.en)
			lines[write_addr] <= fill_data.line;
	end

	// A fill to the line being read returns the new data
	always_ff @(posedge clk)
	begin
		if (read_en)
		begin
			if (fill_data.en && write_addr == read_addr)
				read_data <= fill_data.line;
			else
				read_data <= lines[read_addr];
		end
	end
endmodule

`default_nettype wire

// File: dcache_miss_control.sv
// Miss, store, LRU and IO strobes plus the writeback stage register
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_control(
	input wire logic clk,
	input wire logic reset,
	input dcache_pkg::mem_request_t request,
	input dcache_pkg::request_class_t req_class,
	input wire logic hit,
	input dcache_pkg::way_idx_t hit_way,
	input wire logic near_miss,
	input wire logic [dcache_pkg::CACHE_LINE_BYTES - 1:0] store_mask,
	input dcache_pkg::cache_line_data_t store_data,
	input wire logic rollback_en,
	input dcache_pkg::thread_idx_t rollback_thread,
	output dcache_pkg::io_request_t io_req,
	output dcache_pkg::store_request_t store_req,
	output dcache_pkg::miss_request_t miss_req,
	output dcache_pkg::lru_update_t lru_update,
	output dcache_pkg::writeback_t writeback);

	import dcache_pkg::*;

	logic cache_access;
	logic load_miss;
	writeback_t wb_next;

	assign cache_access = req_class.cache_load || req_class.cache_store;
	assign load_miss = req_class.cache_load && !hit;

	// Near miss retries through rollback instead of asking L2 again
	assign miss_req.en = load_miss && !near_miss && !req_class.unaligned;
	assign miss_req.address = {request.address.cache.tag, request.address.cache.set_idx,
		{CACHE_LINE_OFFSET_WIDTH{1'b0}}};
	assign miss_req.thread = request.thread;
	assign miss_req.synchronized = req_class.synchronized;

	assign store_req.en = req_class.cache_store && !req_class.unaligned;
	assign store_req.mask = store_mask;
	assign store_req.address = request.address;
	assign store_req.data = store_data;
	assign store_req.thread = request.thread;
	assign store_req.synchronized = req_class.synchronized;

	// Hit is already limited to cache accesses
	assign lru_update.en = hit && !req_class.unaligned;
	assign lru_update.way = hit_way;

	assign io_req.write_en = req_class.io_access && !request.is_load;
	assign io_req.read_en = req_class.io_access && request.is_load;
	assign io_req.thread = request.thread;
	assign io_req.address = {16'd0, request.address.io.offset};
	assign io_req.write_value = request.store_value[0];

	always_comb
	begin
		wb_next.valid = request.valid && !(rollback_en && rollback_thread == request.thread);
		wb_next.thread = request.thread;
		wb_next.address = request.address;
		wb_next.access_type = request.access_type;
		wb_next.lane_mask = request.lane_mask;
		wb_next.subcycle = request.subcycle;
		wb_next.rollback_en = load_miss;
		wb_next.rollback_pc = request.pc;
		wb_next.suspend_thread = miss_req.en;
		wb_next.is_io_address = req_class.io_access;
		wb_next.access_fault = req_class.unaligned && cache_access;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			writeback <= '0;
		else
			writeback <= wb_next;
	end
endmodule

`default_nettype wire

// File: dcache_data_stage.sv
// L1 data cache data stage that checks hits, reads lines, aligns stores and handles misses
`timescale 1ns/1ps
`default_nettype none

module dcache_data_stage(
	input wire logic clk,
	input wire logic reset,

	// From the tag stage
	input dcache_pkg::mem_request_t request,
	input dcache_pkg::way_tag_t [dcache_pkg::L1D_WAYS - 1:0] way_tags,

	// From the writeback stage
	input wire logic rollback_en,
	input dcache_pkg::thread_idx_t rollback_thread,

	// From L2
	input dcache_pkg::fill_data_t fill_data,
	input dcache_pkg::fill_tag_t fill_tag,

	// Same-cycle strobes
	output dcache_pkg::io_request_t io_req,
	output dcache_pkg::store_request_t store_req,
	output dcache_pkg::miss_request_t miss_req,
	output dcache_pkg::lru_update_t lru_update,

	// To the writeback stage, one cycle later
	output dcache_pkg::writeback_t writeback,
	output dcache_pkg::cache_line_data_t load_data);

	import dcache_pkg::*;

	request_class_t req_class;
	logic hit;
	way_idx_t hit_way;
	logic near_miss;
	logic [CACHE_LINE_BYTES - 1:0] store_mask;
	cache_line_data_t store_data;

	dcache_request_decode request_decode(
		.request(request),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.store_mask_nonzero(|store_mask),
		.req_class(req_class));

	dcache_hit_check hit_check(
		.clk(clk),
		.reset(reset),
		.request(request),
		.way_tags(way_tags),
		.req_class(req_class),
		.fill_tag(fill_tag),
		.hit(hit),
		.hit_way(hit_way),
		.near_miss(near_miss));

	dcache_store_align store_align(
		.request(request),
		.store_mask(store_mask),
		.store_data(store_data));

	// Hit only rises for cache accesses, so it doubles as the read enable
	dcache_data_sram data_sram(
		.clk(clk),
		.read_en(hit),
		.read_way(hit_way),
		.read_set(request.address.cache.set_idx),
		.read_data(load_data),
		.fill_data(fill_data));

	dcache_miss_control miss_control(
		.clk(clk),
		.reset(reset),
		.request(request),
		.req_class(req_class),
		.hit(hit),
		.hit_way(hit_way),
		.near_miss(near_miss),
		.store_mask(store_mask),
		.store_data(store_data),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.io_req(io_req),
		.store_req(store_req),
		.miss_req(miss_req),
		.lru_update(lru_update),
		.writeback(writeback));
endmodule

`default_nettype wire

// File: tb_dcache_data_stage.sv
// Testbench for the data cache data stage with a tag and line model, reference rules and checks
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_data_stage;
	import dcache_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES = 20000;
	localparam int DRIVE_DELAY = 1;

	logic clk;
	logic reset;
	mem_request_t request;
	way_tag_t [L1D_WAYS - 1:0] way_tags;
	logic rollback_en;
	thread_idx_t rollback_thread;
	fill_data_t fill_data;
	fill_tag_t fill_tag;
	io_request_t io_req;
	store_request_t store_req;
	miss_request_t miss_req;
	lru_update_t lru_update;
	writeback_t writeback;
	cache_line_data_t load_data;

	// Tag stage and data array model
	logic tag_valid[L1D_WAYS][L1D_SETS];
	tag_t tag_model[L1D_WAYS][L1D_SETS];
	cache_line_data_t line_model[L1D_WAYS][L1D_SETS];
	logic [THREADS_PER_CORE - 1:0] sync_model;

	// Side inputs for the next issued cycle
	fill_data_t next_fill;
	fill_tag_t next_fill_tag;
	logic next_rb_en;
	thread_idx_t next_rb_thread;

	// Registered results expected one cycle after a request
	writeback_t exp_wb;
	logic exp_read;
	cache_line_data_t exp_line;

	int checks;
	int errors;

	dcache_data_stage dut0(
		.clk(clk),
		.reset(reset),
		.request(request),
		.way_tags(way_tags),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.fill_data(fill_data),
		.fill_tag(fill_tag),
		.io_req(io_req),
		.store_req(store_req),
		.miss_req(miss_req),
		.lru_update(lru_update),
		.writeback(writeback),
		.load_data(load_data));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("Simulation ran past %0d cycles without finishing", MAX_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [511:0] actual,
			input logic [511:0] expected);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("MISMATCH %s: got %0h, expected %0h at %0t", name, actual, expected, $time);
		end
	endtask

	function automatic int access_size(input mem_access_t access);
		case (access)
			MEM_B, MEM_BX: return 1;
			MEM_S, MEM_SX: return 2;
			MEM_BLOCK: return 64;
			default: return 4;
		endcase
	endfunction

	function automatic logic is_unaligned(input mem_request_t req);
		scalar_t addr;
		addr = req.address;
		return int'(addr[5:0]) % access_size(req.access_type) != 0;
	endfunction

	// Line byte b owns mask bit 63 - b
	function automatic logic [CACHE_LINE_BYTES - 1:0] store_mask_for(input mem_request_t req);
		logic [CACHE_LINE_BYTES - 1:0] mask;
		scalar_t addr;
		int off;
		int size;
		addr = req.address;
		off = int'(addr[5:0]);
		size = access_size(req.access_type);
		for (int b = 0; b < CACHE_LINE_BYTES; b++)
		begin
			case (req.access_type)
				MEM_BLOCK: mask[63 - b] = req.lane_mask[15 - b / 4];
				MEM_SCGATH: mask[63 - b] = b / 4 == off / 4 && req.lane_mask[15 - req.subcycle];
				default: mask[63 - b] = b / size == off / size;
			endcase
		end
		return mask;
	endfunction

	// Low byte of each value goes to the lowest address of its slot
	function automatic cache_line_data_t aligned_store_line(input mem_request_t req);
		cache_line_data_t line;
		scalar_t word;
		int slot;
		slot = access_size(req.access_type) > 4 ? 4 : access_size(req.access_type);
		for (int b = 0; b < CACHE_LINE_BYTES; b++)
		begin
			case (req.access_type)
				MEM_BLOCK: word = req.store_value[15 - b / 4];
				MEM_SCGATH: word = req.store_value[15 - req.subcycle];
				default: word = req.store_value[0];
			endcase
			line[511 - 8 * b -: 8] = word[8 * (b % slot) +: 8];
		end
		return line;
	endfunction

	function automatic mem_request_t make_req(input logic is_load, input mem_access_t access,
			input thread_idx_t thread, input scalar_t addr);
		mem_request_t req;
		req = '0;
		req.valid = 1'b1;
		req.is_load = is_load;
		req.access_type = access;
		req.thread = thread;
		req.address = addr;
		req.pc = addr ^ 32'h0000_4000;
		req.lane_mask = '1;
		return req;
	endfunction

	// Checks every cycle against the reference rules
	always @(negedge clk)
	begin
		scalar_t addr;
		int set;
		int way;
		logic tag_hit;
		logic is_io;
		logic active;
		logic cache_load;
		logic cache_store;
		logic sync;
		logic unaligned;
		logic hit;
		logic near_miss;
		logic miss;
		logic [CACHE_LINE_BYTES - 1:0] mask;

		if (reset)
		begin
			exp_wb = '0;
			exp_read = 1'b0;
			sync_model = '0;
		end
		else
		begin
			check_value("writeback.valid", writeback.valid, exp_wb.valid);
			check_value("writeback.rollback_en", writeback.rollback_en, exp_wb.rollback_en);
			check_value("writeback.suspend_thread", writeback.suspend_thread,
				exp_wb.suspend_thread);
			check_value("writeback.access_fault", writeback.access_fault, exp_wb.access_fault);
			check_value("writeback.is_io_address", writeback.is_io_address,
				exp_wb.is_io_address);
			if (exp_wb.valid)
			begin
				check_value("writeback.thread", writeback.thread, exp_wb.thread);
				check_value("writeback.address", writeback.address, exp_wb.address);
				check_value("writeback.rollback_pc", writeback.rollback_pc, exp_wb.rollback_pc);
				check_value("writeback.access_type", writeback.access_type,
					exp_wb.access_type);
				check_value("writeback.lane_mask", writeback.lane_mask, exp_wb.lane_mask);
				check_value("writeback.subcycle", writeback.subcycle, exp_wb.subcycle);
			end
			if (exp_read)
				check_value("load_data", load_data, exp_line);

			addr = request.address;
			set = int'(addr[11:6]);
			is_io = addr[31:16] == 16'hFFFF;
			active = request.valid && !(rollback_en && rollback_thread == request.thread);
			mask = store_mask_for(request);
			cache_load = active && !is_io && request.is_load;
			cache_store = active && !is_io && !request.is_load && |mask;
			sync = request.access_type == MEM_SYNC;
			unaligned = is_unaligned(request);
			tag_hit = 1'b0;
			way = 0;
			for (int w = 0; w < L1D_WAYS; w++)
			begin
				if (tag_valid[w][set] && tag_model[w][set] == addr[31:12])
				begin
					tag_hit = 1'b1;
					way = w;
				end
			end
			hit = (cache_load || cache_store) && tag_hit && (!sync || sync_model[request.thread]);
			near_miss = cache_load && !hit && !sync && |fill_tag.way_en
				&& fill_tag.set == addr[11:6] && fill_tag.tag == addr[31:12];
			miss = cache_load && !hit && !near_miss && !unaligned;

			check_value("miss_req.en", miss_req.en, miss);
			if (miss)
			begin
				check_value("miss_req.address", miss_req.address, {addr[31:6], 6'b0});
				check_value("miss_req.synchronized", miss_req.synchronized, sync);
				check_value("miss_req.thread", miss_req.thread, request.thread);
			end
			check_value("store_req.en", store_req.en, cache_store && !unaligned);
			if (cache_store && !unaligned)
			begin
				check_value("store_req.mask", store_req.mask, mask);
				check_value("store_req.data", store_req.data, aligned_store_line(request));
				check_value("store_req.address", store_req.address, addr);
				check_value("store_req.thread", store_req.thread, request.thread);
				check_value("store_req.synchronized", store_req.synchronized, sync);
			end
			check_value("lru_update.en", lru_update.en, hit && !unaligned);
			if (hit && !unaligned)
				check_value("lru_update.way", lru_update.way, way);
			check_value("io_req.read_en", io_req.read_en, active && is_io && request.is_load);
			check_value("io_req.write_en", io_req.write_en, active && is_io && !request.is_load);
			if (active && is_io)
			begin
				check_value("io_req.address", io_req.address, {16'h0000, addr[15:0]});
				check_value("io_req.thread", io_req.thread, request.thread);
			end

			exp_wb = '0;
			exp_wb.valid = active;
			exp_wb.thread = request.thread;
			exp_wb.address = request.address;
			exp_wb.access_type = request.access_type;
			exp_wb.lane_mask = request.lane_mask;
			exp_wb.subcycle = request.subcycle;
			exp_wb.rollback_pc = request.pc;
			exp_wb.rollback_en = cache_load && !hit;
			exp_wb.suspend_thread = miss;
			exp_wb.access_fault = unaligned && (cache_load || cache_store);
			exp_wb.is_io_address = active && is_io;
			exp_read = hit;
			if (fill_data.en && int'(fill_data.way) == way && fill_data.set == addr[11:6])
				exp_line = fill_data.line;
			else
				exp_line = line_model[way][set];
			if (fill_data.en)
				line_model[fill_data.way][fill_data.set] = fill_data.line;
			if (cache_load && sync)
				sync_model[request.thread] = !sync_model[request.thread];
		end
	end

	// One request per call, with tags of its set taken from the model
	task automatic issue(input mem_request_t req);
		int set;
		@(posedge clk);
		#DRIVE_DELAY;
		set = int'(req.address.cache.set_idx);
		request = req;
		for (int w = 0; w < L1D_WAYS; w++)
		begin
			way_tags[w].valid = tag_valid[w][set];
			way_tags[w].tag = tag_model[w][set];
		end
		fill_data = next_fill;
		fill_tag = next_fill_tag;
		rollback_en = next_rb_en;
		rollback_thread = next_rb_thread;
		next_fill = '0;
		next_fill_tag = '0;
		next_rb_en = 1'b0;
	endtask

	task automatic wait_writeback(input int limit);
		int cycles;
		cycles = 0;
		do
		begin
			issue('0);
			@(negedge clk);
			cycles++;
		end
		while (!writeback.valid && cycles < limit);
		checks++;
		assert (writeback.valid)
		else
		begin
			errors++;
			$display("Writeback valid did not rise within %0d cycles", limit);
		end
	endtask

	task automatic install_line(input way_idx_t way, input scalar_t addr,
			output cache_line_data_t line);
		for (int i = 0; i < CACHE_LINE_WORDS; i++)
			line[i * 32 +: 32] = $urandom();
		next_fill.en = 1'b1;
		next_fill.way = way;
		next_fill.set = addr[11:6];
		next_fill.line = line;
		issue('0);
		tag_valid[way][addr[11:6]] = 1'b1;
		tag_model[way][addr[11:6]] = addr[31:12];
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errors - errors_before);
	endtask

	task automatic hit_after_fill();
		int errors_before;
		cache_line_data_t line;
		errors_before = errors;
		install_line(2'd2, 32'h1234_5680, line);
		issue(make_req(1'b1, MEM_L, 2'd0, 32'h1234_5688));
		@(negedge clk);
		check_value("lru_update.en", lru_update.en, 1'b1);
		check_value("lru_update.way", lru_update.way, 2'd2);
		check_value("miss_req.en", miss_req.en, 1'b0);
		wait_writeback(4);
		check_value("load_data", load_data, line);
		check_value("writeback.rollback_en", writeback.rollback_en, 1'b0);
		report_test("fill and load hit", errors_before);
	endtask

	task automatic miss_and_near_miss();
		int errors_before;
		errors_before = errors;
		issue(make_req(1'b1, MEM_L, 2'd1, 32'h0042_1104));
		@(negedge clk);
		check_value("miss_req.en", miss_req.en, 1'b1);
		check_value("miss_req.address", miss_req.address, 32'h0042_1100);
		wait_writeback(4);
		check_value("writeback.rollback_en", writeback.rollback_en, 1'b1);
		check_value("writeback.suspend_thread", writeback.suspend_thread, 1'b1);

		// Tag fill for the same line lands in the request cycle
		next_fill_tag.way_en = 4'b0001;
		next_fill_tag.set = 6'h09;
		next_fill_tag.tag = 20'h00772;
		issue(make_req(1'b1, MEM_L, 2'd3, 32'h0077_2240));
		@(negedge clk);
		check_value("miss_req.en", miss_req.en, 1'b0);
		wait_writeback(4);
		check_value("writeback.rollback_en", writeback.rollback_en, 1'b1);
		check_value("writeback.suspend_thread", writeback.suspend_thread, 1'b0);
		report_test("load miss and near miss", errors_before);
	endtask

	task automatic random_stores();
		int errors_before;
		int stores_seen;
		mem_request_t req;
		scalar_t addr;
		errors_before = errors;
		stores_seen = 0;
		for (int n = 0; n < 200; n++)
		begin
			addr = {1'b0, 31'($urandom())};
			req = make_req(1'b0, mem_access_t'($urandom_range(7, 0)),
				thread_idx_t'($urandom_range(3, 0)), addr);
			// Three out of four are aligned
			if ($urandom_range(3, 0) != 0)
				addr[5:0] = addr[5:0] & ~6'(access_size(req.access_type) - 1);
			req.address = addr;
			req.lane_mask = lane_mask_t'($urandom());
			req.subcycle = subcycle_t'($urandom_range(15, 0));
			for (int i = 0; i < CACHE_LINE_WORDS; i++)
				req.store_value[i] = $urandom();
			issue(req);
			@(negedge clk);
			if (store_req.en)
				stores_seen++;
		end
		checks++;
		assert (stores_seen > 0)
		else
		begin
			errors++;
			$display("No random store reached the cache");
		end
		report_test("random stores", errors_before);
	endtask

	task automatic check_fault(input logic is_load, input mem_access_t access, input scalar_t addr);
		issue(make_req(is_load, access, 2'd0, addr));
		@(negedge clk);
		check_value("store_req.en", store_req.en, 1'b0);
		check_value("miss_req.en", miss_req.en, 1'b0);
		wait_writeback(4);
		check_value("writeback.access_fault", writeback.access_fault, 1'b1);
	endtask

	task automatic faults_and_io();
		int errors_before;
		mem_request_t req;
		errors_before = errors;
		check_fault(1'b0, MEM_S, 32'h0010_0201);
		check_fault(1'b1, MEM_L, 32'h0010_0202);
		check_fault(1'b0, MEM_BLOCK, 32'h0010_0204);
		check_fault(1'b1, MEM_SCGATH, 32'h0010_0203);

		issue(make_req(1'b1, MEM_L, 2'd2, 32'hFFFF_0124));
		@(negedge clk);
		check_value("io_req.read_en", io_req.read_en, 1'b1);
		check_value("io_req.address", io_req.address, 32'h0000_0124);
		check_value("miss_req.en", miss_req.en, 1'b0);
		req = make_req(1'b0, MEM_L, 2'd2, 32'hFFFF_0458);
		req.store_value[0] = 32'hCAFE_F00D;
		issue(req);
		@(negedge clk);
		check_value("io_req.write_en", io_req.write_en, 1'b1);
		check_value("io_req.write_value", io_req.write_value, 32'hCAFE_F00D);
		check_value("store_req.en", store_req.en, 1'b0);
		wait_writeback(4);
		check_value("writeback.is_io_address", writeback.is_io_address, 1'b1);
		check_value("writeback.access_fault", writeback.access_fault, 1'b0);
		report_test("faults and IO", errors_before);
	endtask

	task automatic sync_and_cancel();
		int errors_before;
		cache_line_data_t line;
		errors_before = errors;
		install_line(2'd1, 32'h0005_6700, line);
		issue(make_req(1'b1, MEM_SYNC, 2'd1, 32'h0005_6700));
		@(negedge clk);
		check_value("miss_req.en", miss_req.en, 1'b1);
		check_value("miss_req.synchronized", miss_req.synchronized, 1'b1);
		wait_writeback(4);
		check_value("writeback.rollback_en", writeback.rollback_en, 1'b1);
		issue(make_req(1'b1, MEM_SYNC, 2'd1, 32'h0005_6700));
		@(negedge clk);
		check_value("lru_update.en", lru_update.en, 1'b1);
		check_value("miss_req.en", miss_req.en, 1'b0);
		wait_writeback(4);
		check_value("writeback.rollback_en", writeback.rollback_en, 1'b0);

		// Rollback of the request's own thread squashes it
		next_rb_en = 1'b1;
		next_rb_thread = 2'd2;
		issue(make_req(1'b1, MEM_L, 2'd2, 32'h0005_6700));
		@(negedge clk);
		check_value("lru_update.en", lru_update.en, 1'b0);
		check_value("miss_req.en", miss_req.en, 1'b0);
		issue('0);
		@(negedge clk);
		check_value("writeback.valid", writeback.valid, 1'b0);
		report_test("synchronized load and rollback", errors_before);
	endtask

	initial
	begin
		void'($urandom(32'h8635_b3ee));
		checks = 0;
		errors = 0;
		reset = 1'b1;
		request = '0;
		way_tags = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		fill_data = '0;
		fill_tag = '0;
		next_fill = '0;
		next_fill_tag = '0;
		next_rb_en = 1'b0;
		next_rb_thread = '0;
		for (int w = 0; w < L1D_WAYS; w++)
		begin
			for (int s = 0; s < L1D_SETS; s++)
			begin
				tag_valid[w][s] = 1'b0;
				tag_model[w][s] = '0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		hit_after_fill();
		miss_and_near_miss();
		random_stores();
		faults_and_io();
		sync_and_cancel();
		repeat (4) issue('0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: dcache_data_stage.f
dcache_pkg.sv
dcache_request_decode.sv
dcache_hit_check.sv
dcache_store_align.sv
dcache_data_sram.sv
dcache_miss_control.sv
dcache_data_stage.sv
tb_dcache_data_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the data stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dcache_data_stage \
	-f dcache_data_stage.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed" >&2
	exit 1
fi
